// ==== hdl/scatter_config.svh ====
/*
 * Build-time sizes for the packet scatter subsystem:
 * data word width in bytes, buffer count and words per buffer
 */
`ifndef SCATTER_CONFIG_SVH
`define SCATTER_CONFIG_SVH

// Bytes carried by one stream word
`define SCATTER_DATA_BYTES 8

// Buffers managed by the free list
`define SCATTER_NUM_BUFFERS 8

// Words per buffer which makes the largest packet 64 bytes
`define SCATTER_BUFFER_WORDS 8

`endif

// ==== hdl/scatter_pkg.sv ====
/*
 * Shared types of the packet scatter subsystem: vector typedefs,
 * stream word, descriptor and event structs, status and FSM enums
 */
`include "scatter_config.svh"

package scatter_pkg;

    // --------------------
    // Vector types
    typedef logic [`SCATTER_DATA_BYTES*8-1:0]                 data_word_t;
    typedef logic [$clog2(`SCATTER_DATA_BYTES)-1:0]           mty_t;
    typedef logic [7:0]                                       meta_t;
    typedef logic [$clog2(`SCATTER_NUM_BUFFERS)-1:0]          buf_ptr_t;
    typedef logic [$clog2(`SCATTER_BUFFER_WORDS)-1:0]         word_idx_t;
    typedef logic [$bits(buf_ptr_t)+$bits(word_idx_t)-1:0]    mem_addr_t;
    typedef logic [6:0]                                       pkt_size_t;
    typedef logic [15:0]                                      stat_cnt_t;
    typedef logic [1:0]                                       reg_addr_t;
    typedef logic [15:0]                                      reg_data_t;

    // --------------------
    // Enums
    typedef enum logic [1:0] {
        STATUS_OK    = 2'd0,
        STATUS_ERR   = 2'd1,
        STATUS_SHORT = 2'd2,
        STATUS_LONG  = 2'd3
    } pkt_status_t;

    typedef enum logic [1:0] {
        ST_INIT  = 2'd0,
        ST_SOP   = 2'd1,
        ST_MOP   = 2'd2,
        ST_FLUSH = 2'd3
    } scatter_state_t;

    // --------------------
    // Structs
    typedef struct packed {
        data_word_t data;
        mty_t       mty;
        logic       eop;
        logic       err;
        meta_t      meta;
    } pkt_word_t;

    typedef struct packed {
        buf_ptr_t  ptr;
        pkt_size_t size;
        meta_t     meta;
        logic      err;
    } desc_t;

    typedef struct packed {
        pkt_status_t status;
    } pkt_event_t;

endpackage

// ==== hdl/buffer_free_list.sv ====
/*
 * Free buffer pointer FIFO with self-fill after reset,
 * pop on allocation and merged release and recycle pushes
 */
`timescale 1ns/1ps
`include "scatter_config.svh"

module buffer_free_list import scatter_pkg::*; (
    input  logic     clk,
    input  logic     srst,
    input  logic     alloc_pop,
    input  logic     rel_vld,
    input  buf_ptr_t rel_ptr,
    input  logic     recycle_vld,
    input  buf_ptr_t recycle_ptr,
    output logic     alloc_vld,
    output buf_ptr_t alloc_ptr,
    output logic     init_done
);
    localparam int NUM_BUFS = `SCATTER_NUM_BUFFERS;
    localparam int CNT_W    = $clog2(NUM_BUFS + 1);

    buf_ptr_t         slots [NUM_BUFS];
    buf_ptr_t         rd_idx;
    buf_ptr_t         wr_idx;
    logic [CNT_W-1:0] count;
    buf_ptr_t         fill_idx;
    logic             pop;
    logic             push_a;
    logic             push_b;
    buf_ptr_t         push_a_ptr;
    buf_ptr_t         push_b_ptr;

    // --------------------
    // Push selection with release first when both arrive
    always_comb begin
        push_a     = 1'b0;
        push_b     = 1'b0;
        push_a_ptr = fill_idx;
        push_b_ptr = recycle_ptr;
        if (!init_done) begin
            push_a = 1'b1;
        end else if (rel_vld) begin
            push_a     = 1'b1;
            push_a_ptr = rel_ptr;
            push_b     = recycle_vld;
        end else if (recycle_vld) begin
            push_a     = 1'b1;
            push_a_ptr = recycle_ptr;
        end
    end

    assign pop = alloc_pop && (count != '0);

    // Pointer storage
    always_ff @(posedge clk) begin
        if (push_a) slots[wr_idx] <= push_a_ptr;
        if (push_b) slots[buf_ptr_t'(wr_idx + 1'b1)] <= push_b_ptr;
    end

    // --------------------
    // Indices, occupancy and init sequence
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_idx    <= '0;
            wr_idx    <= '0;
            count     <= '0;
            fill_idx  <= '0;
            init_done <= 1'b0;
        end else begin
            if (!init_done) begin
                fill_idx <= fill_idx + 1'b1;
                if (fill_idx == buf_ptr_t'(NUM_BUFS - 1)) init_done <= 1'b1;
            end
            if (pop) rd_idx <= rd_idx + 1'b1;
            wr_idx <= wr_idx + buf_ptr_t'(push_a) + buf_ptr_t'(push_b);
            count  <= count + CNT_W'(push_a) + CNT_W'(push_b) - CNT_W'(pop);
        end
    end

    assign alloc_vld = (count != '0);
    assign alloc_ptr = slots[rd_idx];

endmodule

// ==== hdl/packet_scatter.sv ====
/*
 * Packet write FSM: buffer allocation, word writes, size and
 * status judgement, descriptor or recycle, and packet event
 */
`timescale 1ns/1ps
`include "scatter_config.svh"

module packet_scatter import scatter_pkg::*; (
    input  logic       clk,
    input  logic       srst,
    input  logic       init_done,
    input  logic       in_vld,
    input  pkt_word_t  in_word,
    output logic       in_rdy,
    input  logic       alloc_vld,
    input  buf_ptr_t   alloc_ptr,
    output logic       alloc_pop,
    output logic       mem_wr,
    output mem_addr_t  mem_waddr,
    output data_word_t mem_wdata,
    input  logic       desc_rdy,
    output logic       desc_vld,
    output desc_t      desc,
    output logic       recycle_vld,
    output buf_ptr_t   recycle_ptr,
    input  pkt_size_t  cfg_min_size,
    input  logic       cfg_drop_err,
    output logic       evt_vld,
    output pkt_event_t evt
);
    localparam int BUF_WORDS = `SCATTER_BUFFER_WORDS;
    localparam int WCNT_W    = $clog2(BUF_WORDS + 1);

    scatter_state_t    state;
    scatter_state_t    nxt_state;
    logic              accept;
    logic              sop_acc;
    logic              eop_acc;
    logic              full;
    logic              oflow_word;
    logic [WCNT_W-1:0] wr_cnt;
    buf_ptr_t          ptr_r;
    buf_ptr_t          cur_ptr;
    word_idx_t         cur_idx;
    logic              oflow;
    logic              pkt_done;
    mty_t              mty_r;
    logic              err_r;
    meta_t             meta_r;
    pkt_size_t         pkt_size;
    pkt_status_t       status;
    logic              keep;

    // --------------------
    // Packet write FSM
    always_ff @(posedge clk) begin
        if (srst) state <= ST_INIT;
        else      state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        in_rdy    = 1'b0;
        case (state)
            ST_INIT: begin
                if (init_done) nxt_state = ST_SOP;
            end
            ST_SOP: begin
                // New packet needs a free buffer and room for its descriptor
                in_rdy = alloc_vld && desc_rdy;
                if (in_vld && alloc_vld && desc_rdy && !in_word.eop) nxt_state = ST_MOP;
            end
            ST_MOP: begin
                in_rdy = 1'b1;
                if (in_vld) begin
                    if (in_word.eop) nxt_state = ST_SOP;
                    else if (full)   nxt_state = ST_FLUSH;
                end
            end
            ST_FLUSH: begin
                in_rdy = 1'b1;
                if (in_vld && in_word.eop) nxt_state = ST_SOP;
            end
            default: begin
                nxt_state = ST_INIT;
            end
        endcase
    end

    assign accept     = in_vld && in_rdy;
    assign sop_acc    = accept && (state == ST_SOP);
    assign eop_acc    = accept && in_word.eop;
    assign full       = (wr_cnt == WCNT_W'(BUF_WORDS));
    assign oflow_word = accept && (state == ST_MOP) && full;

    // --------------------
    // Buffer write path
    assign cur_ptr   = (state == ST_SOP) ? alloc_ptr : ptr_r;
    assign cur_idx   = (state == ST_SOP) ? '0 : word_idx_t'(wr_cnt);
    assign alloc_pop = sop_acc;
    assign mem_wr    = sop_acc || (accept && (state == ST_MOP) && !full);
    assign mem_waddr = {cur_ptr, cur_idx};
    assign mem_wdata = in_word.data;

    // Word count and overflow flag held through the end-of-packet cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_cnt <= '0;
            oflow  <= 1'b0;
        end else if (sop_acc) begin
            wr_cnt <= WCNT_W'(1);
            oflow  <= 1'b0;
        end else begin
            if (mem_wr)     wr_cnt <= wr_cnt + 1'b1;
            if (oflow_word) oflow  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sop_acc) ptr_r <= alloc_ptr;
    end

    // --------------------
    // End-of-packet context
    always_ff @(posedge clk) begin
        if (srst) pkt_done <= 1'b0;
        else      pkt_done <= eop_acc;
    end

    always_ff @(posedge clk) begin
        if (eop_acc) begin
            mty_r  <= in_word.mty;
            err_r  <= in_word.err;
            meta_r <= in_word.meta;
        end
    end

    assign pkt_size = pkt_size_t'(wr_cnt) * pkt_size_t'(`SCATTER_DATA_BYTES)
                      - pkt_size_t'(mty_r);

    // Status in priority order
    always_comb begin
        if (err_r && cfg_drop_err)      status = STATUS_ERR;
        else if (oflow)                 status = STATUS_LONG;
        else if (pkt_size < cfg_min_size) status = STATUS_SHORT;
        else if (err_r)                 status = STATUS_ERR;
        else                            status = STATUS_OK;
    end

    assign keep = (status == STATUS_OK) || ((status == STATUS_ERR) && !cfg_drop_err);

    // --------------------
    // Descriptor, recycle and event
    assign desc_vld    = pkt_done && keep;
    assign desc.ptr    = ptr_r;
    assign desc.size   = pkt_size;
    assign desc.meta   = meta_r;
    assign desc.err    = err_r;

    assign recycle_vld = pkt_done && !keep;
    assign recycle_ptr = ptr_r;

    assign evt_vld     = pkt_done;
    assign evt.status  = status;

endmodule

// ==== hdl/buffer_mem.sv ====
/*
 * Packet buffer memory, one write port and one registered read port
 */
`timescale 1ns/1ps
`include "scatter_config.svh"

module buffer_mem import scatter_pkg::*; (
    input  logic       clk,
    input  logic       wr,
    input  mem_addr_t  waddr,
    input  data_word_t wdata,
    input  mem_addr_t  raddr,
    output data_word_t rdata
);
    localparam int DEPTH = `SCATTER_NUM_BUFFERS * `SCATTER_BUFFER_WORDS;

    data_word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr) mem[waddr] <= wdata;
    end

    // Read data lands one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hdl/scatter_regs.sv ====
/*
 * Configuration registers and saturating packet counters
 * on a simple write/read register bus
 */
`timescale 1ns/1ps

module scatter_regs import scatter_pkg::*; (
    input  logic       clk,
    input  logic       srst,
    input  logic       reg_wr,
    input  reg_addr_t  reg_addr,
    input  reg_data_t  reg_wdata,
    output reg_data_t  reg_rdata,
    output pkt_size_t  cfg_min_size,
    output logic       cfg_drop_err,
    input  logic       evt_vld,
    input  pkt_event_t evt
);
    stat_cnt_t issued_cnt;
    stat_cnt_t dropped_cnt;
    logic      evt_kept;

    // --------------------
    // Configuration
    always_ff @(posedge clk) begin
        if (srst) begin
            cfg_min_size <= '0;
            cfg_drop_err <= 1'b1;
        end else if (reg_wr) begin
            if (reg_addr == 2'd0) cfg_min_size <= pkt_size_t'(reg_wdata);
            if (reg_addr == 2'd1) cfg_drop_err <= reg_wdata[0];
        end
    end

    // Errored packets only count as issued when they are kept
    assign evt_kept = (evt.status == STATUS_OK) ||
                      ((evt.status == STATUS_ERR) && !cfg_drop_err);

    // --------------------
    // Statistics counters cleared by a write
    always_ff @(posedge clk) begin
        if (srst) begin
            issued_cnt  <= '0;
            dropped_cnt <= '0;
        end else begin
            if (reg_wr && (reg_addr == 2'd2)) begin
                issued_cnt <= '0;
            end else if (evt_vld && evt_kept && (issued_cnt != '1)) begin
                issued_cnt <= issued_cnt + 1'b1;
            end
            if (reg_wr && (reg_addr == 2'd3)) begin
                dropped_cnt <= '0;
            end else if (evt_vld && !evt_kept && (dropped_cnt != '1)) begin
                dropped_cnt <= dropped_cnt + 1'b1;
            end
        end
    end

    // Read mux
    always_comb begin
        case (reg_addr)
            2'd0:    reg_rdata = reg_data_t'(cfg_min_size);
            2'd1:    reg_rdata = reg_data_t'(cfg_drop_err);
            2'd2:    reg_rdata = issued_cnt;
            default: reg_rdata = dropped_cnt;
        endcase
    end

endmodule

// ==== hdl/scatter_top.sv ====
/*
 * Packet scatter top: register block, free list,
 * scatter engine and buffer memory
 */
`timescale 1ns/1ps

module scatter_top import scatter_pkg::*; (
    input  logic       clk,
    input  logic       srst,
    input  logic       in_vld,
    input  pkt_word_t  in_word,
    output logic       in_rdy,
    output logic       desc_vld,
    output desc_t      desc,
    input  logic       desc_rdy,
    input  logic       rel_vld,
    input  buf_ptr_t   rel_ptr,
    input  mem_addr_t  rd_addr,
    output data_word_t rd_data,
    input  logic       reg_wr,
    input  reg_addr_t  reg_addr,
    input  reg_data_t  reg_wdata,
    output reg_data_t  reg_rdata
);
    logic       init_done;
    logic       alloc_vld;
    buf_ptr_t   alloc_ptr;
    logic       alloc_pop;
    logic       recycle_vld;
    buf_ptr_t   recycle_ptr;
    logic       mem_wr;
    mem_addr_t  mem_waddr;
    data_word_t mem_wdata;
    pkt_size_t  cfg_min_size;
    logic       cfg_drop_err;
    logic       evt_vld;
    pkt_event_t evt;

    scatter_regs scatter_regs_i (
        .clk, .srst, .reg_wr, .reg_addr, .reg_wdata, .reg_rdata,
        .cfg_min_size, .cfg_drop_err, .evt_vld, .evt
    );

    buffer_free_list buffer_free_list_i (
        .clk, .srst, .alloc_pop, .rel_vld, .rel_ptr, .recycle_vld,
        .recycle_ptr, .alloc_vld, .alloc_ptr, .init_done
    );

    packet_scatter packet_scatter_i (
        .clk, .srst, .init_done, .in_vld, .in_word, .in_rdy,
        .alloc_vld, .alloc_ptr, .alloc_pop, .mem_wr, .mem_waddr, .mem_wdata,
        .desc_rdy, .desc_vld, .desc, .recycle_vld, .recycle_ptr,
        .cfg_min_size, .cfg_drop_err, .evt_vld, .evt
    );

    // Consumer reads packet data through the top-level read port
    buffer_mem buffer_mem_i (
        .clk,
        .wr    (mem_wr),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

// ==== test/scatter_asserts.sv ====
/*
 * Handshake assertions bound into the scatter top
 */
`timescale 1ns/1ps

module scatter_asserts import scatter_pkg::*; (
    input logic      clk,
    input logic      srst,
    input logic      init_done,
    input logic      in_vld,
    input pkt_word_t in_word,
    input logic      in_rdy,
    input logic      desc_vld
);
    int fail_count = 0;

    // No input accepted before the free list is filled
    a_rdy_after_init: assert property (@(posedge clk) disable iff (srst)
        !init_done |-> !in_rdy)
        else begin
            fail_count++;
            $error("in_rdy high before init end");
        end

    // Descriptor one cycle after an accepted eop word
    a_desc_after_eop: assert property (@(posedge clk) disable iff (srst)
        desc_vld |-> $past(in_vld && in_rdy && in_word.eop))
        else begin
            fail_count++;
            $error("desc_vld without an accepted eop");
        end

    a_word_stable: assert property (@(posedge clk) disable iff (srst)
        (in_vld && !in_rdy) ##1 in_vld |-> $stable(in_word))
        else begin
            fail_count++;
            $error("in_word changed while stalled");
        end
endmodule

bind scatter_top scatter_asserts scatter_asserts_i (.*);

// ==== test/scatter_tb.sv ====
/*
 * Testbench for the packet scatter top: stimulus, reference model,
 * descriptor and buffer readback checks, timeout and report
 */
`timescale 1ns/1ps
`include "scatter_config.svh"

module scatter_tb import scatter_pkg::*; ();
    localparam int MAX_WORDS = 40 * 8 + 8 * 8 + 5 * 12 + 8 * 8 + 9 * 8;
    localparam int LIMIT     = MAX_WORDS * 4 + 2000;

    logic clk = 1'b0;
    logic srst, in_vld, in_rdy, desc_vld, desc_rdy, rel_vld, reg_wr;
    pkt_word_t  in_word;
    desc_t      desc;
    buf_ptr_t   rel_ptr;
    mem_addr_t  rd_addr;
    data_word_t rd_data;
    reg_addr_t  reg_addr;
    reg_data_t  reg_wdata, reg_rdata;

    desc_t      rx_q[$], exp_desc_q[$];
    int         exp_nw_q[$];
    data_word_t exp_data_q[$];
    buf_ptr_t   held_q[$];
    bit         in_use[`SCATTER_NUM_BUFFERS];
    bit         hold = 0, busy = 0;
    int         value_errs = 0, other_errs = 0, cycles = 0;
    stat_cnt_t  m_issued = 0, m_dropped = 0;
    pkt_size_t  m_min_size = 0;
    logic       m_drop_err = 1'b1;

    scatter_top scatter_top_i (.*);

    always #20 clk = ~clk;

    // --------------------
    // Timeout
    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Expected status from the packet rule in priority order
    function automatic pkt_status_t ref_status(input int nwords, input mty_t mty,
                                               input logic err, output pkt_size_t size);
        size = pkt_size_t'(nwords * `SCATTER_DATA_BYTES - mty);
        if (err && m_drop_err) return STATUS_ERR;
        if (nwords > `SCATTER_BUFFER_WORDS) return STATUS_LONG;
        if (size < m_min_size) return STATUS_SHORT;
        if (err) return STATUS_ERR;
        return STATUS_OK;
    endfunction

    // --------------------
    // Compare tasks
    task automatic check_desc(input desc_t exp, input desc_t got);
        if (got.size !== exp.size || got.meta !== exp.meta || got.err !== exp.err) begin
            value_errs++;
            $display("[FAIL] %0t desc exp size=%0d meta=%h err=%b got size=%0d meta=%h err=%b",
                     $time, exp.size, exp.meta, exp.err, got.size, got.meta, got.err);
        end
    endtask

    task automatic check_word(input string name, input data_word_t exp, input data_word_t got);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input stat_cnt_t exp, input stat_cnt_t got);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %0t %s exp=%0d got=%0d", $time, name, exp, got);
        end
    endtask

    // --------------------
    // Bus helpers
    task automatic release_buf(input buf_ptr_t p);
        @(negedge clk);
        rel_vld = 1'b1;
        rel_ptr = p;
        in_use[p] = 1'b0;
        @(negedge clk);
        rel_vld = 1'b0;
    endtask

    task automatic reg_write(input reg_addr_t a, input reg_data_t d);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t a, output reg_data_t d);
        @(negedge clk);
        reg_addr = a;
        #2 d = reg_rdata;
    endtask

    task automatic wait_idle();
        do begin
            repeat (3) @(negedge clk);
            #2;
        end while (busy || rx_q.size() != 0 || exp_desc_q.size() != 0);
    endtask

    task automatic send_packet(input int nwords, input logic err, input bit gaps);
        pkt_word_t   w;
        data_word_t  words[$];
        mty_t        mty;
        meta_t       meta;
        pkt_size_t   size;
        pkt_status_t st;
        desc_t       e;
        bit          taken;
        mty  = mty_t'($urandom);
        meta = meta_t'($urandom);
        for (int i = 0; i < nwords; i++) begin
            if (gaps) begin
                repeat ($urandom_range(0, 2)) begin
                    @(negedge clk);
                    in_vld = 1'b0;
                end
            end
            @(negedge clk);
            w.data = {$urandom, $urandom};
            w.eop  = (i == nwords - 1);
            w.mty  = w.eop ? mty : '0;
            w.err  = w.eop ? err : 1'b0;
            w.meta = meta;
            in_vld  = 1'b1;
            in_word = w;
            words.push_back(w.data);
            taken = 0;
            while (!taken) begin
                #2 taken = in_rdy;
                if (!taken) @(negedge clk);
            end
        end
        // Last word transfers on the coming edge
        st = ref_status(nwords, mty, err, size);
        if (st == STATUS_OK || (st == STATUS_ERR && !m_drop_err)) begin
            e = '0;
            e.size = size;
            e.meta = meta;
            e.err  = err;
            exp_desc_q.push_back(e);
            exp_nw_q.push_back(nwords);
            foreach (words[k]) exp_data_q.push_back(words[k]);
            m_issued++;
        end else begin
            m_dropped++;
        end
        @(negedge clk);
        in_vld = 1'b0;
    endtask

    // --------------------
    // Descriptor capture and compare
    always @(negedge clk) begin
        if (desc_vld) rx_q.push_back(desc);
    end

    initial begin
        desc_t exp, got;
        int    n;
        forever begin
            wait (rx_q.size() != 0);
            busy = 1;
            got = rx_q.pop_front();
            if (exp_desc_q.size() == 0) begin
                other_errs++;
                $display("Descriptor at %0t with no packet expecting one", $time);
            end else begin
                exp = exp_desc_q.pop_front();
                n   = exp_nw_q.pop_front();
                check_desc(exp, got);
                if (in_use[got.ptr]) begin
                    other_errs++;
                    $display("Buffer %0d handed out while still in use at %0t", got.ptr, $time);
                end
                in_use[got.ptr] = 1'b1;
                for (int i = 0; i < n; i++) begin
                    @(negedge clk);
                    rd_addr = {got.ptr, word_idx_t'(i)};
                    @(negedge clk);
                    check_word("rd_data", exp_data_q.pop_front(), rd_data);
                end
                if (hold) held_q.push_back(got.ptr);
                else      release_buf(got.ptr);
            end
            busy = 0;
        end
    end

    // --------------------
    // Main sequence
    initial begin
        reg_data_t d;
        int        assert_errs;
        void'($urandom(32'h6f0));
        srst = 1'b1;
        in_vld = 1'b0;
        in_word = '0;
        desc_rdy = 1'b1;
        rel_vld = 1'b0;
        rel_ptr = '0;
        rd_addr = '0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        repeat (5) @(negedge clk);
        srst = 1'b0;

        // Outputs stay quiet through init before in_rdy rises
        repeat (8) begin
            @(negedge clk);
            #2;
            if (in_rdy || desc_vld) begin
                other_errs++;
                $display("in_rdy or desc_vld high during init at %0t", $time);
            end
        end
        repeat (4) @(negedge clk);
        if (!in_rdy) begin
            other_errs++;
            $display("in_rdy did not rise after init");
        end

        repeat (40) send_packet($urandom_range(1, 8), 1'b0, 1'b1);
        wait_idle();

        // Two words stay below 20 bytes and four words always reach past it
        reg_write(2'd0, 16'd20);
        m_min_size = 20;
        repeat (4) begin
            send_packet($urandom_range(1, 2), 1'b0, 1'b1);
            send_packet($urandom_range(4, 8), 1'b0, 1'b1);
        end
        wait_idle();
        reg_write(2'd0, 16'd0);
        m_min_size = 0;

        repeat (4) send_packet($urandom_range(9, 12), 1'b0, 1'b1);
        send_packet(5, 1'b0, 1'b0);
        wait_idle();

        repeat (4) send_packet($urandom_range(1, 8), 1'b1, 1'b1);
        wait_idle();
        reg_write(2'd1, 16'd0);
        m_drop_err = 1'b0;
        repeat (4) send_packet($urandom_range(1, 8), 1'b1, 1'b1);
        wait_idle();
        reg_write(2'd1, 16'd1);
        m_drop_err = 1'b1;

        // Hold all buffers until one release lets the next packet in
        hold = 1;
        repeat (8) send_packet($urandom_range(1, 8), 1'b0, 1'b0);
        wait_idle();
        fork
            send_packet(3, 1'b0, 1'b0);
            begin
                repeat (10) begin
                    @(negedge clk);
                    #2;
                    if (in_rdy) begin
                        other_errs++;
                        $display("in_rdy high with no free buffer at %0t", $time);
                    end
                end
                release_buf(held_q.pop_front());
            end
        join
        wait_idle();
        while (held_q.size() != 0) release_buf(held_q.pop_front());
        hold = 0;
        send_packet(4, 1'b0, 1'b0);
        wait_idle();

        reg_read(2'd2, d);
        check_count("issued_cnt", m_issued, stat_cnt_t'(d));
        reg_read(2'd3, d);
        check_count("dropped_cnt", m_dropped, stat_cnt_t'(d));

        assert_errs = scatter_top_i.scatter_asserts_i.fail_count;
        $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errs, other_errs, assert_errs);
        if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end
endmodule

// ==== project.f ====
+incdir+hdl
hdl/scatter_pkg.sv
hdl/buffer_free_list.sv
hdl/packet_scatter.sv
hdl/buffer_mem.sv
hdl/scatter_regs.sv
hdl/scatter_top.sv
test/scatter_asserts.sv
test/scatter_tb.sv

// ==== Bender.yml ====
package:
  name: packet_scatter

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/scatter_pkg.sv
      - hdl/buffer_free_list.sv
      - hdl/packet_scatter.sv
      - hdl/buffer_mem.sv
      - hdl/scatter_regs.sv
      - hdl/scatter_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/scatter_asserts.sv
      - test/scatter_tb.sv
